// ==== sim.f ====
tdd_regmap_pkg.sv
tdd_ctrl_regs.sv
tdd_channel_regs.sv
tdd_read_mux.sv
tdd_regmap_top.sv
tb_tdd_regmap.sv

// ==== Makefile ====
# Verilator build and run for the tdd register map testbench

TOP       ?= tb_tdd_regmap
FILELIST  ?= sim.f
VERILATOR ?= verilator
VFLAGS    ?= -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --binary -f $(FILELIST) --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== tb_tdd_regmap.sv ====
// ****************************************
// self-checking testbench for the tdd register map
// runs a table of bus writes, readbacks and output checks
// ****************************************
`timescale 1ns/1ns

module tb_tdd_regmap;

  localparam int k_write = 0;
  localparam int k_read  = 1;
  localparam int k_out   = 2;
  localparam int ack_timeout = 20;

  logic        up_clk;
  logic        up_rstn;
  logic        up_wreq;
  logic [13:0] up_waddr;
  logic [31:0] up_wdata;
  logic        up_wack;
  logic        up_rreq;
  logic [13:0] up_raddr;
  logic [31:0] up_rdata;
  logic        up_rack;
  logic [1:0]  tdd_cstate;
  logic        tdd_enable;
  logic        tdd_sync_rst;
  logic        tdd_sync_int;
  logic        tdd_sync_ext;
  logic        tdd_sync_soft;
  logic [7:0]  tdd_channel_en;
  logic [7:0]  tdd_channel_pol;
  logic [31:0] tdd_burst_count;
  logic [31:0] tdd_startup_delay;
  logic [31:0] tdd_frame_length;
  logic [63:0] tdd_sync_period;
  logic [31:0] tdd_channel_on  [0:7];
  logic [31:0] tdd_channel_off [0:7];

  // stimulus table with one entry per row in each queue
  int          kind_q[$];
  logic [7:0]  ofs_q[$];
  logic [31:0] data_q[$];
  logic [31:0] exp_q[$];

  int          seed = 32'heac9;
  logic [31:0] scratch_word;

  tdd_regmap_top u_dut (
    .up_clk            (up_clk),
    .up_rstn           (up_rstn),
    .up_wreq           (up_wreq),
    .up_waddr          (up_waddr),
    .up_wdata          (up_wdata),
    .up_wack           (up_wack),
    .up_rreq           (up_rreq),
    .up_raddr          (up_raddr),
    .up_rdata          (up_rdata),
    .up_rack           (up_rack),
    .tdd_cstate        (tdd_cstate),
    .tdd_enable        (tdd_enable),
    .tdd_sync_rst      (tdd_sync_rst),
    .tdd_sync_int      (tdd_sync_int),
    .tdd_sync_ext      (tdd_sync_ext),
    .tdd_sync_soft     (tdd_sync_soft),
    .tdd_channel_en    (tdd_channel_en),
    .tdd_channel_pol   (tdd_channel_pol),
    .tdd_burst_count   (tdd_burst_count),
    .tdd_startup_delay (tdd_startup_delay),
    .tdd_frame_length  (tdd_frame_length),
    .tdd_sync_period   (tdd_sync_period),
    .tdd_channel_on    (tdd_channel_on),
    .tdd_channel_off   (tdd_channel_off)
  );

  initial begin
    up_clk = 1'b0;
    forever #5 up_clk = ~up_clk;
  end

  task automatic check_value(input string msg, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, msg, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopping after the first error");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t ns: no %s within %0d cycles", $time, what, ack_timeout);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping after a bus timeout");
  endtask

  task automatic add_row(input int kind, input logic [7:0] ofs,
                         input logic [31:0] data, input logic [31:0] exp);
    kind_q.push_back(kind);
    ofs_q.push_back(ofs);
    data_q.push_back(data);
    exp_q.push_back(exp);
  endtask

  // one-cycle write strobe that returns in the cycle up_wack is high
  task automatic bus_write(input logic [7:0] ofs, input logic [31:0] data);
    int waited;
    up_waddr = {6'd0, ofs};
    up_wdata = data;
    up_wreq  = 1'b1;
    @(negedge up_clk);
    up_wreq = 1'b0;
    waited  = 0;
    while (!up_wack) begin
      if (waited >= ack_timeout) report_timeout("write acknowledge");
      @(negedge up_clk);
      waited++;
    end
  endtask

  // read strobe with cstate driven for status reads
  task automatic bus_read(input logic [7:0] ofs, input logic [1:0] cstate,
                          output logic [31:0] data);
    int waited;
    tdd_cstate = cstate;
    up_raddr   = {6'd0, ofs};
    up_rreq    = 1'b1;
    @(negedge up_clk);
    up_rreq = 1'b0;
    waited  = 0;
    while (!up_rack) begin
      if (waited >= ack_timeout) report_timeout("read acknowledge");
      @(negedge up_clk);
      waited++;
    end
    data = up_rdata;
    // no request in this cycle so ack and data bus are back at zero
    @(negedge up_clk);
    check_value("rack after read", up_rack, 32'h0);
    check_value("rdata after read", up_rdata, 32'h0);
  endtask

  // DUT outputs that belong to a register offset
  function automatic logic [31:0] output_value(input logic [7:0] ofs);
    if (ofs[7:4] == 4'h4) begin
      return ofs[0] ? tdd_channel_off[ofs[3:1]] : tdd_channel_on[ofs[3:1]];
    end
    case (ofs)
      8'h10:   return {27'd0, tdd_sync_soft, tdd_sync_ext, tdd_sync_int, tdd_sync_rst, tdd_enable};
      8'h11:   return {24'd0, tdd_channel_en};
      8'h12:   return {24'd0, tdd_channel_pol};
      8'h13:   return tdd_burst_count;
      8'h14:   return tdd_startup_delay;
      8'h15:   return tdd_frame_length;
      8'h16:   return tdd_sync_period[31:0];
      8'h17:   return tdd_sync_period[63:32];
      default: return 32'hffffffff;
    endcase
  endfunction

  initial begin
    logic [31:0] got;
    logic [7:0]  ch_ofs;
    logic [31:0] on_val;
    logic [31:0] off_val;
    int          ch_list[3];

    up_rstn    = 1'b0;
    up_wreq    = 1'b0;
    up_waddr   = '0;
    up_wdata   = '0;
    up_rreq    = 1'b0;
    up_raddr   = '0;
    tdd_cstate = 2'd0;
    ch_list    = '{0, 3, 7};
    scratch_word = $random(seed);

    // ****************************************
    // stimulus table
    // ****************************************
    add_row(k_out,   8'h10, 32'h0,        32'h0);
    add_row(k_read,  8'h00, 32'h0,        32'h00020161);
    add_row(k_read,  8'h01, 32'h0,        32'h00000000);
    add_row(k_read,  8'h03, 32'h0,        32'h54444443);
    add_row(k_read,  8'h04, 32'h0,        32'h40202017);
    add_row(k_read,  8'h05, 32'h0,        32'h0);
    add_row(k_read,  8'h3f, 32'h0,        32'h0);
    add_row(k_write, 8'h02, scratch_word, 32'h0);
    add_row(k_read,  8'h02, 32'h0,        scratch_word);
    // only the low eight bits of the masks are kept
    add_row(k_write, 8'h11, 32'hffffffa5, 32'h0);
    add_row(k_out,   8'h11, 32'h0,        32'h000000a5);
    add_row(k_read,  8'h11, 32'h0,        32'h000000a5);
    add_row(k_write, 8'h12, 32'h0000013c, 32'h0);
    add_row(k_out,   8'h12, 32'h0,        32'h0000003c);
    add_row(k_read,  8'h12, 32'h0,        32'h0000003c);
    add_row(k_write, 8'h13, 32'h00000100, 32'h0);
    add_row(k_write, 8'h14, 32'h00000020, 32'h0);
    add_row(k_write, 8'h15, 32'h00001000, 32'h0);
    add_row(k_write, 8'h16, 32'h89abcdef, 32'h0);
    add_row(k_write, 8'h17, 32'h01234567, 32'h0);
    add_row(k_out,   8'h13, 32'h0,        32'h00000100);
    add_row(k_out,   8'h14, 32'h0,        32'h00000020);
    add_row(k_out,   8'h15, 32'h0,        32'h00001000);
    add_row(k_out,   8'h16, 32'h0,        32'h89abcdef);
    add_row(k_out,   8'h17, 32'h0,        32'h01234567);
    add_row(k_read,  8'h16, 32'h0,        32'h89abcdef);
    add_row(k_read,  8'h17, 32'h0,        32'h01234567);
    foreach (ch_list[i]) begin
      ch_ofs  = {4'h4, 3'(ch_list[i]), 1'b0};
      on_val  = 32'h10000000 | 32'(ch_list[i] * 17);
      off_val = 32'h20000000 | 32'(ch_list[i] * 17);
      add_row(k_write, ch_ofs,        on_val,  32'h0);
      add_row(k_write, ch_ofs | 8'h1, off_val, 32'h0);
      add_row(k_out,   ch_ofs,        32'h0,   on_val);
      add_row(k_out,   ch_ofs | 8'h1, 32'h0,   off_val);
      add_row(k_read,  ch_ofs,        32'h0,   on_val);
      add_row(k_read,  ch_ofs | 8'h1, 32'h0,   off_val);
    end
    // soft sync shows in the ack cycle and then drops
    add_row(k_write, 8'h10, 32'h0000001f, 32'h0);
    add_row(k_out,   8'h10, 32'h0,        32'h00000017);
    add_row(k_out,   8'h10, 32'h0,        32'h00000007);
    add_row(k_read,  8'h10, 32'h0,        32'h00000007);
    // timing registers stay locked while the engine runs
    add_row(k_write, 8'h13, 32'h0000ffff, 32'h0);
    add_row(k_out,   8'h13, 32'h0,        32'h00000100);
    add_row(k_read,  8'h13, 32'h0,        32'h00000100);
    add_row(k_write, 8'h14, 32'h0000ffff, 32'h0);
    add_row(k_write, 8'h15, 32'h0000ffff, 32'h0);
    add_row(k_write, 8'h16, 32'hffffffff, 32'h0);
    add_row(k_out,   8'h14, 32'h0,        32'h00000020);
    add_row(k_out,   8'h15, 32'h0,        32'h00001000);
    add_row(k_out,   8'h16, 32'h0,        32'h89abcdef);
    add_row(k_read,  8'h14, 32'h0,        32'h00000020);
    add_row(k_read,  8'h15, 32'h0,        32'h00001000);
    add_row(k_read,  8'h16, 32'h0,        32'h89abcdef);
    add_row(k_write, 8'h17, 32'hffffffff, 32'h0);
    add_row(k_out,   8'h17, 32'h0,        32'h01234567);
    add_row(k_read,  8'h17, 32'h0,        32'h01234567);
    add_row(k_write, 8'h12, 32'h000000ff, 32'h0);
    add_row(k_out,   8'h12, 32'h0,        32'h0000003c);
    add_row(k_read,  8'h12, 32'h0,        32'h0000003c);
    add_row(k_write, 8'h40, 32'h0000dead, 32'h0);
    add_row(k_out,   8'h40, 32'h0,        32'h10000000);
    add_row(k_read,  8'h40, 32'h0,        32'h10000000);
    add_row(k_write, 8'h11, 32'h0000000f, 32'h0);
    add_row(k_out,   8'h11, 32'h0,        32'h0000000f);
    add_row(k_read,  8'h11, 32'h0,        32'h0000000f);
    for (int s = 0; s < 4; s++) begin
      add_row(k_read, 8'h18, 32'(s), 32'(s));
    end

    repeat (4) @(posedge up_clk);
    @(negedge up_clk);
    up_rstn = 1'b1;
    @(negedge up_clk);
    check_value("rdata idle after reset", up_rdata, 32'h0);

    for (int i = 0; i < kind_q.size(); i++) begin
      if (kind_q[i] == k_write) begin
        bus_write(ofs_q[i], data_q[i]);
      end else if (kind_q[i] == k_read) begin
        bus_read(ofs_q[i], data_q[i][1:0], got);
        check_value($sformatf("row %0d readback at offset %h", i, ofs_q[i]), got, exp_q[i]);
      end else begin
        check_value($sformatf("row %0d output for offset %h", i, ofs_q[i]),
                    output_value(ofs_q[i]), exp_q[i]);
        @(negedge up_clk);
      end
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== tdd_regmap_top.sv ====
// ****************************************
// tdd register map top level
// ties the write, channel and read blocks to the processor bus
// ****************************************
`timescale 1ns/1ns

module tdd_regmap_top (
  input  logic                                  up_clk,
  input  logic                                  up_rstn,
  // processor bus
  input  logic                                  up_wreq,
  input  logic [tdd_regmap_pkg::addr_width-1:0] up_waddr,
  input  logic [tdd_regmap_pkg::data_width-1:0] up_wdata,
  output logic                                  up_wack,
  input  logic                                  up_rreq,
  input  logic [tdd_regmap_pkg::addr_width-1:0] up_raddr,
  output logic [tdd_regmap_pkg::data_width-1:0] up_rdata,
  output logic                                  up_rack,
  // timing engine
  input  logic [1:0]                            tdd_cstate,
  output logic                                  tdd_enable,
  output logic                                  tdd_sync_rst,
  output logic                                  tdd_sync_int,
  output logic                                  tdd_sync_ext,
  output logic                                  tdd_sync_soft,
  output logic [tdd_regmap_pkg::ch_count-1:0]   tdd_channel_en,
  output logic [tdd_regmap_pkg::ch_count-1:0]   tdd_channel_pol,
  output logic [tdd_regmap_pkg::data_width-1:0] tdd_burst_count,
  output logic [tdd_regmap_pkg::data_width-1:0] tdd_startup_delay,
  output logic [tdd_regmap_pkg::data_width-1:0] tdd_frame_length,
  output logic [tdd_regmap_pkg::sync_width-1:0] tdd_sync_period,
  output logic [tdd_regmap_pkg::data_width-1:0] tdd_channel_on  [0:tdd_regmap_pkg::ch_count-1],
  output logic [tdd_regmap_pkg::data_width-1:0] tdd_channel_off [0:tdd_regmap_pkg::ch_count-1]
);

  logic [tdd_regmap_pkg::data_width-1:0] scratch;

  tdd_ctrl_regs u_ctrl_regs (
    .up_clk            (up_clk),
    .up_rstn           (up_rstn),
    .up_wreq           (up_wreq),
    .up_waddr          (up_waddr),
    .up_wdata          (up_wdata),
    .up_wack           (up_wack),
    .scratch           (scratch),
    .tdd_enable        (tdd_enable),
    .tdd_sync_rst      (tdd_sync_rst),
    .tdd_sync_int      (tdd_sync_int),
    .tdd_sync_ext      (tdd_sync_ext),
    .tdd_sync_soft     (tdd_sync_soft),
    .tdd_channel_en    (tdd_channel_en),
    .tdd_channel_pol   (tdd_channel_pol),
    .tdd_burst_count   (tdd_burst_count),
    .tdd_startup_delay (tdd_startup_delay),
    .tdd_frame_length  (tdd_frame_length),
    .tdd_sync_period   (tdd_sync_period)
  );

  tdd_channel_regs u_channel_regs (
    .up_clk          (up_clk),
    .up_rstn         (up_rstn),
    .up_wreq         (up_wreq),
    .up_waddr        (up_waddr),
    .up_wdata        (up_wdata),
    .tdd_enable      (tdd_enable),
    .tdd_channel_on  (tdd_channel_on),
    .tdd_channel_off (tdd_channel_off)
  );

  tdd_read_mux u_read_mux (
    .up_clk            (up_clk),
    .up_rstn           (up_rstn),
    .up_rreq           (up_rreq),
    .up_raddr          (up_raddr),
    .tdd_cstate        (tdd_cstate),
    .scratch           (scratch),
    .tdd_enable        (tdd_enable),
    .tdd_sync_rst      (tdd_sync_rst),
    .tdd_sync_int      (tdd_sync_int),
    .tdd_sync_ext      (tdd_sync_ext),
    .tdd_sync_soft     (tdd_sync_soft),
    .tdd_channel_en    (tdd_channel_en),
    .tdd_channel_pol   (tdd_channel_pol),
    .tdd_burst_count   (tdd_burst_count),
    .tdd_startup_delay (tdd_startup_delay),
    .tdd_frame_length  (tdd_frame_length),
    .tdd_sync_period   (tdd_sync_period),
    .tdd_channel_on    (tdd_channel_on),
    .tdd_channel_off   (tdd_channel_off),
    .up_rdata          (up_rdata),
    .up_rack           (up_rack)
  );

endmodule

// ==== tdd_read_mux.sv ====
// ****************************************
// read side of the tdd register map
// decodes the read offset, returns data and ack one cycle later
// ****************************************
`timescale 1ns/1ns

module tdd_read_mux (
  input  logic                                  up_clk,
  input  logic                                  up_rstn,
  input  logic                                  up_rreq,
  input  logic [tdd_regmap_pkg::addr_width-1:0] up_raddr,
  input  logic [1:0]                            tdd_cstate,
  input  logic [tdd_regmap_pkg::data_width-1:0] scratch,
  input  logic                                  tdd_enable,
  input  logic                                  tdd_sync_rst,
  input  logic                                  tdd_sync_int,
  input  logic                                  tdd_sync_ext,
  input  logic                                  tdd_sync_soft,
  input  logic [tdd_regmap_pkg::ch_count-1:0]   tdd_channel_en,
  input  logic [tdd_regmap_pkg::ch_count-1:0]   tdd_channel_pol,
  input  logic [tdd_regmap_pkg::data_width-1:0] tdd_burst_count,
  input  logic [tdd_regmap_pkg::data_width-1:0] tdd_startup_delay,
  input  logic [tdd_regmap_pkg::data_width-1:0] tdd_frame_length,
  input  logic [tdd_regmap_pkg::sync_width-1:0] tdd_sync_period,
  input  logic [tdd_regmap_pkg::data_width-1:0] tdd_channel_on  [0:tdd_regmap_pkg::ch_count-1],
  input  logic [tdd_regmap_pkg::data_width-1:0] tdd_channel_off [0:tdd_regmap_pkg::ch_count-1],
  output logic [tdd_regmap_pkg::data_width-1:0] up_rdata,
  output logic                                  up_rack
);

  localparam int dw = tdd_regmap_pkg::data_width;

  tdd_regmap_pkg::reg_ofs_u rofs;
  logic [dw-1:0]            ctl_word;
  logic [dw-1:0]            rdata_s;

  assign rofs.raw = up_raddr[tdd_regmap_pkg::ofs_width-1:0];

  always_comb begin
    ctl_word = '0;
    ctl_word[tdd_regmap_pkg::ctl_enable]    = tdd_enable;
    ctl_word[tdd_regmap_pkg::ctl_sync_rst]  = tdd_sync_rst;
    ctl_word[tdd_regmap_pkg::ctl_sync_int]  = tdd_sync_int;
    ctl_word[tdd_regmap_pkg::ctl_sync_ext]  = tdd_sync_ext;
    ctl_word[tdd_regmap_pkg::ctl_sync_soft] = tdd_sync_soft;
  end

  // ****************************************
  // offset decode
  // ****************************************
  always_comb begin
    rdata_s = '0;
    if (rofs.chan.region == tdd_regmap_pkg::ch_region) begin
      rdata_s = rofs.chan.sel_off ? tdd_channel_off[rofs.chan.ch] : tdd_channel_on[rofs.chan.ch];
    end else begin
      case (rofs.raw)
        tdd_regmap_pkg::ofs_version:   rdata_s = tdd_regmap_pkg::core_version;
        tdd_regmap_pkg::ofs_id:        rdata_s = tdd_regmap_pkg::core_id;
        tdd_regmap_pkg::ofs_scratch:   rdata_s = scratch;
        tdd_regmap_pkg::ofs_identify:  rdata_s = tdd_regmap_pkg::core_magic;
        tdd_regmap_pkg::ofs_interface: rdata_s = tdd_regmap_pkg::interface_word;
        tdd_regmap_pkg::ofs_control:   rdata_s = ctl_word;
        tdd_regmap_pkg::ofs_ch_enable: rdata_s = dw'(tdd_channel_en);
        tdd_regmap_pkg::ofs_polarity:  rdata_s = dw'(tdd_channel_pol);
        tdd_regmap_pkg::ofs_burst:     rdata_s = tdd_burst_count;
        tdd_regmap_pkg::ofs_startup:   rdata_s = tdd_startup_delay;
        tdd_regmap_pkg::ofs_frame:     rdata_s = tdd_frame_length;
        tdd_regmap_pkg::ofs_sync_low:  rdata_s = tdd_sync_period[dw-1:0];
        tdd_regmap_pkg::ofs_sync_high: rdata_s = dw'(tdd_sync_period[tdd_regmap_pkg::sync_width-1:dw]);
        tdd_regmap_pkg::ofs_status:    rdata_s = dw'(tdd_cstate);
        default:                       rdata_s = '0;
      endcase
    end
  end

  // data bus stays at zero outside a read response
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack  <= up_rreq;
      up_rdata <= up_rreq ? rdata_s : '0;
    end
  end

endmodule

// ==== tdd_channel_regs.sv ====
// ****************************************
// per-channel on and off times
// written at 0x40 + 2n (on) and 0x41 + 2n (off)
// ****************************************
`timescale 1ns/1ns

module tdd_channel_regs (
  input  logic                                  up_clk,
  input  logic                                  up_rstn,
  input  logic                                  up_wreq,
  input  logic [tdd_regmap_pkg::addr_width-1:0] up_waddr,
  input  logic [tdd_regmap_pkg::data_width-1:0] up_wdata,
  input  logic                                  tdd_enable,
  output logic [tdd_regmap_pkg::data_width-1:0] tdd_channel_on  [0:tdd_regmap_pkg::ch_count-1],
  output logic [tdd_regmap_pkg::data_width-1:0] tdd_channel_off [0:tdd_regmap_pkg::ch_count-1]
);

  tdd_regmap_pkg::reg_ofs_u wofs;
  logic                     ch_hit;

  assign wofs.raw = up_waddr[tdd_regmap_pkg::ofs_width-1:0];

  // region match, locked out while the engine runs
  assign ch_hit = up_wreq & ~tdd_enable &
                  (wofs.chan.region == tdd_regmap_pkg::ch_region);

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      tdd_channel_on  <= '{default: '0};
      tdd_channel_off <= '{default: '0};
    end else if (ch_hit) begin
      if (wofs.chan.sel_off) begin
        tdd_channel_off[wofs.chan.ch] <= up_wdata;
      end else begin
        tdd_channel_on[wofs.chan.ch] <= up_wdata;
      end
    end
  end

endmodule

// ==== tdd_ctrl_regs.sv ====
// ****************************************
// write side of the common tdd registers
// holds control, masks, timing words and sync period,
// and answers every write request with a one-cycle ack
// ****************************************
`timescale 1ns/1ns

module tdd_ctrl_regs (
  input  logic                                       up_clk,
  input  logic                                       up_rstn,
  input  logic                                       up_wreq,
  input  logic [tdd_regmap_pkg::addr_width-1:0]      up_waddr,
  input  logic [tdd_regmap_pkg::data_width-1:0]      up_wdata,
  output logic                                       up_wack,
  output logic [tdd_regmap_pkg::data_width-1:0]      scratch,
  output logic                                       tdd_enable,
  output logic                                       tdd_sync_rst,
  output logic                                       tdd_sync_int,
  output logic                                       tdd_sync_ext,
  output logic                                       tdd_sync_soft,
  output logic [tdd_regmap_pkg::ch_count-1:0]        tdd_channel_en,
  output logic [tdd_regmap_pkg::ch_count-1:0]        tdd_channel_pol,
  output logic [tdd_regmap_pkg::data_width-1:0]      tdd_burst_count,
  output logic [tdd_regmap_pkg::data_width-1:0]      tdd_startup_delay,
  output logic [tdd_regmap_pkg::data_width-1:0]      tdd_frame_length,
  output logic [tdd_regmap_pkg::sync_width-1:0]      tdd_sync_period
);

  localparam int high_width = tdd_regmap_pkg::sync_width - tdd_regmap_pkg::data_width;

  logic [tdd_regmap_pkg::ofs_width-1:0]  wofs;
  logic                                  wr_open;
  logic [tdd_regmap_pkg::data_width-1:0] sync_low;
  logic [high_width-1:0]                 sync_high;

  assign wofs = up_waddr[tdd_regmap_pkg::ofs_width-1:0];

  // timing registers only accept writes while the engine is stopped
  assign wr_open = up_wreq & ~tdd_enable;

  assign tdd_sync_period = {sync_high, sync_low};

  // ****************************************
  // control and timing state
  // ****************************************
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack           <= 1'b0;
      tdd_enable        <= 1'b0;
      tdd_sync_rst      <= 1'b0;
      tdd_sync_int      <= 1'b0;
      tdd_sync_ext      <= 1'b0;
      tdd_sync_soft     <= 1'b0;
      tdd_channel_en    <= '0;
      tdd_channel_pol   <= '0;
      tdd_burst_count   <= '0;
      tdd_startup_delay <= '0;
      tdd_frame_length  <= '0;
      sync_low          <= '0;
      sync_high         <= '0;
    end else begin
      up_wack <= up_wreq;

      // soft sync is a single pulse, everything else holds
      tdd_sync_soft <= 1'b0;
      if (up_wreq && wofs == tdd_regmap_pkg::ofs_control) begin
        tdd_enable    <= up_wdata[tdd_regmap_pkg::ctl_enable];
        tdd_sync_rst  <= up_wdata[tdd_regmap_pkg::ctl_sync_rst];
        tdd_sync_int  <= up_wdata[tdd_regmap_pkg::ctl_sync_int] &
                         tdd_regmap_pkg::sync_internal_en;
        tdd_sync_ext  <= up_wdata[tdd_regmap_pkg::ctl_sync_ext] &
                         tdd_regmap_pkg::sync_external_en;
        tdd_sync_soft <= up_wdata[tdd_regmap_pkg::ctl_sync_soft];
      end

      // channel enable may change on the fly
      if (up_wreq && wofs == tdd_regmap_pkg::ofs_ch_enable) begin
        tdd_channel_en <= up_wdata[tdd_regmap_pkg::ch_count-1:0];
      end

      if (wr_open) begin
        case (wofs)
          tdd_regmap_pkg::ofs_polarity:  tdd_channel_pol <= up_wdata[tdd_regmap_pkg::ch_count-1:0];
          tdd_regmap_pkg::ofs_burst:     tdd_burst_count   <= up_wdata;
          tdd_regmap_pkg::ofs_startup:   tdd_startup_delay <= up_wdata;
          tdd_regmap_pkg::ofs_frame:     tdd_frame_length  <= up_wdata;
          tdd_regmap_pkg::ofs_sync_low:  sync_low          <= up_wdata;
          tdd_regmap_pkg::ofs_sync_high: sync_high         <= up_wdata[high_width-1:0];
          default: ;
        endcase
      end
    end
  end

  // scratch word for software
  always_ff @(posedge up_clk) begin
    if (up_wreq && wofs == tdd_regmap_pkg::ofs_scratch) begin
      scratch <= up_wdata;
    end
  end

endmodule

// ==== tdd_regmap_pkg.sv ====
// ****************************************
// shared constants of the tdd register map
// widths, offsets, identification words and the
// offset union used by the write and read decoders
// ****************************************

package tdd_regmap_pkg;

  // ****************************************
  // widths and counts
  // ****************************************
  localparam int data_width   = 32;
  localparam int addr_width   = 14;
  localparam int ofs_width    = 8;
  localparam int ch_count     = 8;
  localparam int ch_idx_width = 3;
  localparam int sync_width   = 64;

  // identification
  localparam logic [31:0] core_version = 32'h00020161;
  localparam logic [31:0] core_id      = 32'h00000000;
  localparam logic [31:0] core_magic   = 32'h54444443;

  // supported sync sources, external sync is not built in
  localparam logic sync_internal_en = 1'b1;
  localparam logic sync_external_en = 1'b0;

  // read-only word describing the build
  localparam logic [31:0] interface_word = {8'(sync_width), 8'(data_width), 8'(data_width),
                                            2'b00, sync_external_en, sync_internal_en,
                                            4'(ch_count - 1)};

  // ****************************************
  // register offsets
  // ****************************************
  localparam logic [ofs_width-1:0] ofs_version   = 8'h00;
  localparam logic [ofs_width-1:0] ofs_id        = 8'h01;
  localparam logic [ofs_width-1:0] ofs_scratch   = 8'h02;
  localparam logic [ofs_width-1:0] ofs_identify  = 8'h03;
  localparam logic [ofs_width-1:0] ofs_interface = 8'h04;
  localparam logic [ofs_width-1:0] ofs_control   = 8'h10;
  localparam logic [ofs_width-1:0] ofs_ch_enable = 8'h11;
  localparam logic [ofs_width-1:0] ofs_polarity  = 8'h12;
  localparam logic [ofs_width-1:0] ofs_burst     = 8'h13;
  localparam logic [ofs_width-1:0] ofs_startup   = 8'h14;
  localparam logic [ofs_width-1:0] ofs_frame     = 8'h15;
  localparam logic [ofs_width-1:0] ofs_sync_low  = 8'h16;
  localparam logic [ofs_width-1:0] ofs_sync_high = 8'h17;
  localparam logic [ofs_width-1:0] ofs_status    = 8'h18;

  // upper nibble of the channel on/off block at 0x40
  localparam logic [3:0] ch_region = 4'h4;

  // control word bit positions
  localparam int ctl_enable    = 0;
  localparam int ctl_sync_rst  = 1;
  localparam int ctl_sync_int  = 2;
  localparam int ctl_sync_ext  = 3;
  localparam int ctl_sync_soft = 4;

  // offset seen flat or as region / channel / on-off select
  typedef union packed {
    logic [ofs_width-1:0] raw;
    struct packed {
      logic [3:0]              region;
      logic [ch_idx_width-1:0] ch;
      logic                    sel_off;
    } chan;
  } reg_ofs_u;

endpackage
